// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= clkBoardTb
FILELIST ?= src.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/10ps
PASS_TEXT ?= Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/clkBoardTb.sv ====
`timescale 1ns/10ps

module clkBoardTb;

  localparam int CLK_PERIOD = 100;
  // Cycle budget of reset and each test, summed for the watchdog
  localparam int TOTAL_CYCLES = 4 + 10 + 20 + 200 + 120 + 60 + 2000;

  logic MBOX_CLK;
  logic CLK;
  logic diagCtl;
  logic diagLd;
  logic diagRead;
  clkPkg::diagSelT diagSel;
  clkPkg::ebusNibbleT ebusDataIn;
  clkPkg::cramTimeT cramTime;
  logic mboxWait;
  logic mboxRespIn;
  logic eboxClk;
  logic crmClk;
  logic edpClk;
  logic ctlClk;
  logic eboxSync;
  logic mrReset;
  logic ebusDrive;
  clkPkg::ebusWordT ebusDataOut;

  // Levels that stay put between cycles
  logic waitLevel;
  clkPkg::cramTimeT ctSetting;

  // Cycle model state
  logic [2:0] mDiv;
  logic mGo;
  logic mBurst;
  logic mStep;
  clkPkg::burstCountT mCount;
  clkPkg::rateSelT mRate;
  clkPkg::domainDisT mDis;
  logic mMr;
  clkPkg::phaseT mPhase;
  logic mSync;
  logic mResp;
  logic mEbox;
  logic mCrm;
  logic mEdp;
  logic mCtl;

  integer seed;
  int errorCount;
  int testErrors;
  int testCount;
  int cycleCount;
  int firstAt;
  int secondAt;
  int waited;
  int pulses;
  logic syncBefore;

  clkBoard clkBoard_inst (
    .MBOX_CLK    (MBOX_CLK),
    .CLK         (CLK),
    .diagCtl     (diagCtl),
    .diagLd      (diagLd),
    .diagRead    (diagRead),
    .diagSel     (diagSel),
    .ebusDataIn  (ebusDataIn),
    .cramTime    (cramTime),
    .mboxWait    (mboxWait),
    .mboxRespIn  (mboxRespIn),
    .eboxClk     (eboxClk),
    .crmClk      (crmClk),
    .edpClk      (edpClk),
    .ctlClk      (ctlClk),
    .eboxSync    (eboxSync),
    .mrReset     (mrReset),
    .ebusDrive   (ebusDrive),
    .ebusDataOut (ebusDataOut)
  );

  initial begin
    MBOX_CLK = 1'b0;
    forever #(CLK_PERIOD / 2) MBOX_CLK = ~MBOX_CLK;
  end

  // Watchdog, twice the summed test budgets
  initial begin
    #(2 * TOTAL_CYCLES * CLK_PERIOD);
    $display("Watchdog expired, simulation did not complete in time");
    $display("Finished with errors");
    $finish;
  end

  task automatic countError();
    errorCount++;
    testErrors++;
  endtask

  task automatic checkBit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns %s expected %b got %b", $time, name, expected, actual);
      countError();
    end
  endtask

  task automatic checkWord(input string name, input clkPkg::ebusWordT actual,
                           input clkPkg::ebusWordT expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns %s expected %h got %h", $time, name, expected, actual);
      countError();
    end
  endtask

  task automatic resetModel();
    mDiv = '0;
    mGo = 1'b0;
    mBurst = 1'b0;
    mStep = 1'b0;
    mCount = '0;
    mRate = '0;
    mDis = '0;
    mMr = 1'b1;
    mPhase = '0;
    mSync = 1'b0;
    mResp = 1'b0;
    mEbox = 1'b0;
    mCrm = 1'b0;
    mEdp = 1'b0;
    mCtl = 1'b0;
  endtask

  // One clock edge of the model, from the inputs held before the edge
  task automatic advanceModel();
    logic rateTick;
    logic tick;
    logic fire;
    logic waitOk;
    logic countDown;
    clkPkg::phaseT newPhase;
    rateTick = 1'b1;
    // Lowest rateSel divider bits must all be zero
    for (int b = 0; b < int'(mRate); b++) begin
      if (mDiv[b]) begin
        rateTick = 1'b0;
      end
    end
    tick = rateTick & (mGo | mStep | (mBurst & (mCount != 8'd0)));
    fire = tick & mSync;
    waitOk = !mboxWait || mResp || mMr;
    countDown = tick & mBurst & (mCount != 8'd0);
    newPhase = (mPhase == 3'd7) ? 3'd7 : mPhase + 3'd1;
    // Enables use the disables from before the edge
    mEbox = fire;
    mCrm = fire & !mDis.crm;
    mEdp = fire & !mDis.edp;
    mCtl = fire & !mDis.ctl;
    if (fire) begin
      mPhase = '0;
      mSync = 1'b0;
    end else if (tick) begin
      mPhase = newPhase;
      mSync = (int'(newPhase) >= int'(cramTime) + 1) && waitOk;
    end
    if (mboxRespIn) begin
      mResp = 1'b1;
    end else if (fire) begin
      mResp = 1'b0;
    end
    mDiv = mDiv + 3'd1;
    if (diagCtl && diagSel == clkPkg::FUNC_STEP) begin
      mStep = 1'b1;
    end else if (tick) begin
      mStep = 1'b0;
    end
    if (diagCtl) begin
      mGo = (diagSel == clkPkg::FUNC_START);
      mBurst = (diagSel == clkPkg::FUNC_BURST);
    end
    if (diagCtl && diagSel == clkPkg::FUNC_SET_RESET) begin
      mMr = 1'b1;
    end else if (diagCtl && diagSel == clkPkg::FUNC_CLR_RESET) begin
      mMr = 1'b0;
    end
    if (diagLd && diagSel == clkPkg::LD_BURST_LO) begin
      mCount[3:0] = ebusDataIn;
    end else if (diagLd && diagSel == clkPkg::LD_BURST_HI) begin
      mCount[7:4] = ebusDataIn;
    end else if (countDown) begin
      mCount = mCount - 8'd1;
    end
    if (diagLd && diagSel == clkPkg::LD_RATE) begin
      mRate = ebusDataIn[1:0];
    end
    if (diagLd && diagSel == clkPkg::LD_DIS) begin
      mDis.crm = ebusDataIn[2];
      mDis.edp = ebusDataIn[1];
      mDis.ctl = ebusDataIn[0];
    end
  endtask

  // Read-back word as the status layout defines it
  function automatic clkPkg::ebusWordT expectedWord();
    clkPkg::ebusWordT w;
    w = '0;
    if (diagRead) begin
      case (diagSel)
        3'd0: w = {(mCount == 8'd0), mGo, mBurst, mStep, mCount[7:6]};
        3'd1: w = mCount[5:0];
        3'd2: w = {mMr, mSync, mResp, mPhase};
        3'd3: w = {mRate, mDis.crm, mDis.edp, mDis.ctl, 1'b0};
        default: w = '0;
      endcase
    end
    return w;
  endfunction

  task automatic checkOutputs();
    checkBit("eboxClk", eboxClk, mEbox);
    checkBit("crmClk", crmClk, mCrm);
    checkBit("edpClk", edpClk, mEdp);
    checkBit("ctlClk", ctlClk, mCtl);
    checkBit("eboxSync", eboxSync, mSync);
    checkBit("mrReset", mrReset, mMr);
    checkBit("ebusDrive", ebusDrive, diagRead);
    checkWord("ebusDataOut", ebusDataOut, expectedWord());
  endtask

  // Model steps on the edge, new inputs follow, outputs checked mid cycle
  task automatic runCycle(input logic ctl, input logic ld, input logic rd,
                          input clkPkg::diagSelT sel, input clkPkg::ebusNibbleT data,
                          input logic resp);
    @(posedge MBOX_CLK);
    advanceModel();
    diagCtl <= ctl;
    diagLd <= ld;
    diagRead <= rd;
    diagSel <= sel;
    ebusDataIn <= data;
    mboxRespIn <= resp;
    mboxWait <= waitLevel;
    cramTime <= ctSetting;
    @(negedge MBOX_CLK);
    checkOutputs();
    cycleCount++;
  endtask

  task automatic idleCycles(input int n);
    repeat (n) runCycle(1'b0, 1'b0, 1'b0, 3'd0, 4'd0, 1'b0);
  endtask

  task automatic issueControl(input clkPkg::diagSelT sel);
    runCycle(1'b1, 1'b0, 1'b0, sel, 4'd0, 1'b0);
  endtask

  task automatic issueLoad(input clkPkg::diagSelT sel, input clkPkg::ebusNibbleT data);
    runCycle(1'b0, 1'b1, 1'b0, sel, data, 1'b0);
  endtask

  task automatic readStatus(input clkPkg::diagSelT sel);
    runCycle(1'b0, 1'b0, 1'b1, sel, 4'd0, 1'b0);
  endtask

  // Idles until an eboxClk pulse shows, returns its cycle number
  task automatic waitPulse(input int limit, output int at);
    int n;
    n = 0;
    at = -1;
    while (at < 0 && n < limit) begin
      idleCycles(1);
      n++;
      if (eboxClk) begin
        at = cycleCount;
      end
    end
    if (at < 0) begin
      $display("No eboxClk pulse arrived within %0d cycles", limit);
      countError();
    end
  endtask

  task automatic finishTest(input string name);
    testCount++;
    $display("Test %0d %s: %0d errors", testCount, name, testErrors);
    testErrors = 0;
  endtask

  initial begin
    seed = 51;
    errorCount = 0;
    testErrors = 0;
    testCount = 0;
    cycleCount = 0;
    CLK = 1'b1;
    diagCtl = 1'b0;
    diagLd = 1'b0;
    diagRead = 1'b0;
    diagSel = '0;
    ebusDataIn = '0;
    cramTime = '0;
    mboxWait = 1'b0;
    mboxRespIn = 1'b0;
    waitLevel = 1'b0;
    ctSetting = '0;
    resetModel();
    repeat (3) @(posedge MBOX_CLK);
    CLK <= 1'b0;
    @(negedge MBOX_CLK);
    checkOutputs();

    // Reset state and MR reset functions
    checkBit("mrReset", mrReset, 1'b1);
    checkBit("eboxClk", eboxClk, 1'b0);
    readStatus(3'd3);
    checkWord("ebusDataOut select 3", ebusDataOut, 6'd0);
    issueControl(clkPkg::FUNC_CLR_RESET);
    idleCycles(1);
    checkBit("mrReset", mrReset, 1'b0);
    issueControl(clkPkg::FUNC_SET_RESET);
    idleCycles(1);
    checkBit("mrReset", mrReset, 1'b1);
    finishTest("reset and MR reset");

    // Register loads through the read-back
    issueLoad(clkPkg::LD_RATE, 4'h2);
    issueLoad(clkPkg::LD_DIS, 4'h5);
    issueLoad(clkPkg::LD_BURST_LO, 4'hA);
    issueLoad(clkPkg::LD_BURST_HI, 4'h3);
    readStatus(3'd3);
    checkWord("ebusDataOut select 3", ebusDataOut, 6'b101010);
    readStatus(3'd1);
    checkWord("ebusDataOut select 1", ebusDataOut, 6'b111010);
    readStatus(3'd0);
    checkWord("ebusDataOut select 0", ebusDataOut, 6'b000000);
    issueLoad(clkPkg::LD_BURST_LO, 4'h0);
    issueLoad(clkPkg::LD_BURST_HI, 4'h0);
    readStatus(3'd0);
    checkWord("ebusDataOut select 0", ebusDataOut, 6'b100000);
    issueLoad(clkPkg::LD_RATE, 4'h0);
    issueLoad(clkPkg::LD_DIS, 4'h0);
    finishTest("loads and read-back");

    // Burst of 5 + r ticks at rate r, paced 2**r cycles apart
    for (int r = 0; r < 4; r++) begin
      issueLoad(clkPkg::LD_RATE, clkPkg::ebusNibbleT'(r));
      issueLoad(clkPkg::LD_BURST_LO, clkPkg::ebusNibbleT'(5 + r));
      issueLoad(clkPkg::LD_BURST_HI, 4'h0);
      issueControl(clkPkg::FUNC_BURST);
      readStatus(3'd0);
      waited = 0;
      while (!ebusDataOut[5] && waited < (5 + r) * 8 + 16) begin
        readStatus(3'd0);
        waited++;
      end
      if (!ebusDataOut[5] || waited < (4 + r) * (1 << r) + 1 || waited > (5 + r) * (1 << r)) begin
        $display("Burst of %0d at rate %0d ended after %0d cycles", 5 + r, r, waited);
        countError();
      end
      issueControl(3'd0);
    end
    finishTest("burst at each rate");

    // Free run, EBox period is cramTime + 2 ticks
    issueLoad(clkPkg::LD_RATE, 4'h0);
    for (int ct = 1; ct <= 3; ct += 2) begin
      ctSetting = clkPkg::cramTimeT'(ct);
      issueControl(clkPkg::FUNC_START);
      waitPulse(40, firstAt);
      waitPulse(40, secondAt);
      checkWord("eboxClk period", clkPkg::ebusWordT'(secondAt - firstAt),
                clkPkg::ebusWordT'(ct + 2));
    end
    issueControl(3'd0);
    idleCycles(2);
    pulses = 0;
    repeat (10) begin
      idleCycles(1);
      pulses += int'(eboxClk);
    end
    checkWord("eboxClk pulses after stop", clkPkg::ebusWordT'(pulses), 6'd0);
    // A step fires only if the sync point was already reached
    readStatus(3'd2);
    syncBefore = mSync;
    issueControl(clkPkg::FUNC_STEP);
    pulses = 0;
    repeat (6) begin
      idleCycles(1);
      pulses += int'(eboxClk);
    end
    checkWord("eboxClk pulses after step", clkPkg::ebusWordT'(pulses),
              clkPkg::ebusWordT'(syncBefore));
    finishTest("free run, stop and step");

    // MBox wait stall with EDP disabled
    issueControl(clkPkg::FUNC_CLR_RESET);
    ctSetting = 2'd1;
    waitLevel = 1'b1;
    issueLoad(clkPkg::LD_DIS, 4'b0010);
    issueControl(clkPkg::FUNC_START);
    idleCycles(10);
    repeat (8) begin
      idleCycles(1);
      checkBit("eboxSync", eboxSync, 1'b0);
    end
    runCycle(1'b0, 1'b0, 1'b0, 3'd0, 4'd0, 1'b1);
    waitPulse(20, firstAt);
    checkBit("crmClk", crmClk, 1'b1);
    checkBit("edpClk", edpClk, 1'b0);
    checkBit("ctlClk", ctlClk, 1'b1);
    waitLevel = 1'b0;
    issueLoad(clkPkg::LD_DIS, 4'h0);
    issueControl(3'd0);
    finishTest("MBox wait and domain disables");

    // Random strobes, selects, data, wait and response
    for (int i = 0; i < 2000; i++) begin
      if (i % 64 == 0) begin
        ctSetting = clkPkg::cramTimeT'($random(seed));
      end
      waitLevel = (($random(seed) % 4) == 0);
      runCycle((($random(seed) % 12) == 0), (($random(seed) % 8) == 0),
               (($random(seed) % 2) == 0), clkPkg::diagSelT'($random(seed)),
               clkPkg::ebusNibbleT'($random(seed)), (($random(seed) % 6) == 0));
    end
    finishTest("random stimulus");

    $display("Summary: %0d tests, %0d cycles, %0d errors", testCount, cycleCount, errorCount);
    if (errorCount == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== dv/clkBoard_checker.sv ====
`timescale 1ns/10ps

module clkBoard_checker (
  input logic MBOX_CLK,
  input logic CLK,
  input logic diagRead,
  input logic ebusDrive,
  input logic eboxClk,
  input logic crmClk,
  input logic edpClk,
  input logic ctlClk,
  input logic eboxSync
);

  // EBox clock enable never lasts more than one cycle
  eboxClkSingle: assert property (@(posedge MBOX_CLK) disable iff (CLK) eboxClk |=> !eboxClk)
    else $error("eboxClk high on two cycles running");

  // Domain enables are copies of the EBox enable
  crmNeedsEbox: assert property (@(posedge MBOX_CLK) crmClk |-> eboxClk)
    else $error("crmClk high without eboxClk");
  edpNeedsEbox: assert property (@(posedge MBOX_CLK) edpClk |-> eboxClk)
    else $error("edpClk high without eboxClk");
  ctlNeedsEbox: assert property (@(posedge MBOX_CLK) ctlClk |-> eboxClk)
    else $error("ctlClk high without eboxClk");

  // Bus driver follows the read level
  driveFollowsRead: assert property (@(posedge MBOX_CLK) ebusDrive == diagRead)
    else $error("ebusDrive differs from diagRead");

  // Nothing clocks while in reset
  quietInReset: assert property (@(posedge MBOX_CLK)
      CLK |-> !(eboxClk || crmClk || edpClk || ctlClk || eboxSync))
    else $error("Clock output active during reset");

endmodule

bind clkBoard clkBoard_checker clkBoard_checker_inst (
  .MBOX_CLK  (MBOX_CLK),
  .CLK       (CLK),
  .diagRead  (diagRead),
  .ebusDrive (ebusDrive),
  .eboxClk   (eboxClk),
  .crmClk    (crmClk),
  .edpClk    (edpClk),
  .ctlClk    (ctlClk),
  .eboxSync  (eboxSync)
);

// ==== hdl/clkBoard.sv ====
`timescale 1ns/10ps

module clkBoard (
  input  logic                MBOX_CLK,
  input  logic                CLK,
  input  logic                diagCtl,
  input  logic                diagLd,
  input  logic                diagRead,
  input  clkPkg::diagSelT     diagSel,
  input  clkPkg::ebusNibbleT  ebusDataIn,
  input  clkPkg::cramTimeT    cramTime,
  input  logic                mboxWait,
  input  logic                mboxRespIn,
  output logic                eboxClk,
  output logic                crmClk,
  output logic                edpClk,
  output logic                ctlClk,
  output logic                eboxSync,
  output logic                mrReset,
  output logic                ebusDrive,
  output clkPkg::ebusWordT    ebusDataOut
);

  // Register block to gate control
  clkPkg::ctlFuncT ctlFunc;
  clkPkg::burstLoadT burstLoad;
  clkPkg::rateSelT rateSel;

  // Register block to sync logic
  clkPkg::domainDisT domainDis;

  // Status back to the read-back mux
  clkPkg::gateStatusT gateStatus;
  clkPkg::syncStatusT syncStatus;

  // Paced source clock ticks
  logic srcTick;

  clkDiagRegs diagRegs_inst (
    .MBOX_CLK    (MBOX_CLK),
    .CLK         (CLK),
    .diagCtl     (diagCtl),
    .diagLd      (diagLd),
    .diagRead    (diagRead),
    .diagSel     (diagSel),
    .ebusDataIn  (ebusDataIn),
    .gateStatus  (gateStatus),
    .syncStatus  (syncStatus),
    .ctlFunc     (ctlFunc),
    .burstLoad   (burstLoad),
    .rateSel     (rateSel),
    .domainDis   (domainDis),
    .mrReset     (mrReset),
    .ebusDrive   (ebusDrive),
    .ebusDataOut (ebusDataOut)
  );

  clkGateCtl gateCtl_inst (
    .MBOX_CLK   (MBOX_CLK),
    .CLK        (CLK),
    .ctlFunc    (ctlFunc),
    .burstLoad  (burstLoad),
    .rateSel    (rateSel),
    .srcTick    (srcTick),
    .gateStatus (gateStatus)
  );

  clkEboxSync eboxSync_inst (
    .MBOX_CLK   (MBOX_CLK),
    .CLK        (CLK),
    .srcTick    (srcTick),
    .mrReset    (mrReset),
    .mboxWait   (mboxWait),
    .mboxRespIn (mboxRespIn),
    .cramTime   (cramTime),
    .domainDis  (domainDis),
    .eboxClk    (eboxClk),
    .crmClk     (crmClk),
    .edpClk     (edpClk),
    .ctlClk     (ctlClk),
    .syncStatus (syncStatus)
  );

  // Sync point also goes out to the MBox
  assign eboxSync = syncStatus.eboxSync;

endmodule

// ==== hdl/clkDiagRegs.sv ====
`timescale 1ns/10ps

module clkDiagRegs (
  input  logic                MBOX_CLK,
  input  logic                CLK,
  input  logic                diagCtl,
  input  logic                diagLd,
  input  logic                diagRead,
  input  clkPkg::diagSelT     diagSel,
  input  clkPkg::ebusNibbleT  ebusDataIn,
  input  clkPkg::gateStatusT  gateStatus,
  input  clkPkg::syncStatusT  syncStatus,
  output clkPkg::ctlFuncT     ctlFunc,
  output clkPkg::burstLoadT   burstLoad,
  output clkPkg::rateSelT     rateSel,
  output clkPkg::domainDisT   domainDis,
  output logic                mrReset,
  output logic                ebusDrive,
  output clkPkg::ebusWordT    ebusDataOut
);

  // Qualified load strobes for the local registers
  logic ldRate;
  logic ldDis;

  // Qualified reset control strobes
  logic clrReset;
  logic setReset;

  // Control function decode
  // Any control strobe counts as a load, so go and burst mode
  // are reloaded even by the reset functions
  always_comb begin
    ctlFunc.load = diagCtl;
    ctlFunc.start = diagCtl && (diagSel == clkPkg::FUNC_START);
    ctlFunc.burst = diagCtl && (diagSel == clkPkg::FUNC_BURST);
    ctlFunc.step = diagCtl && (diagSel == clkPkg::FUNC_STEP);
  end

  assign clrReset = diagCtl && (diagSel == clkPkg::FUNC_CLR_RESET);
  assign setReset = diagCtl && (diagSel == clkPkg::FUNC_SET_RESET);

  // Load function decode
  // Burst nibbles go straight to the counter in the gate block
  always_comb begin
    burstLoad.loadLo = diagLd && (diagSel == clkPkg::LD_BURST_LO);
    burstLoad.loadHi = diagLd && (diagSel == clkPkg::LD_BURST_HI);
    burstLoad.data = ebusDataIn;
  end

  assign ldRate = diagLd && (diagSel == clkPkg::LD_RATE);
  assign ldDis = diagLd && (diagSel == clkPkg::LD_DIS);

  // Rate select from data bits 34 and 35
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      rateSel <= '0;
    end else if (ldRate) begin
      rateSel <= ebusDataIn[1:0];
    end
  end

  // Domain disables, data bits 33 to 35 as crm, edp, ctl
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      domainDis <= '0;
    end else if (ldDis) begin
      domainDis <= clkPkg::domainDisT'(ebusDataIn[2:0]);
    end
  end

  // MR reset flop
  // Comes up set, released by function 6, forced again by function 7
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      mrReset <= 1'b1;
    end else if (setReset) begin
      mrReset <= 1'b1;
    end else if (clrReset) begin
      mrReset <= 1'b0;
    end
  end

  // Bus driver enable tracks the read strobe level
  assign ebusDrive = diagRead;

  // Status read-back, MSB is EBus bit 30
  always_comb begin
    ebusDataOut = '0;
    if (diagRead) begin
      case (diagSel)
        3'd0: ebusDataOut = {gateStatus.burstZero,
                             gateStatus.go,
                             gateStatus.burstMode,
                             gateStatus.stepPending,
                             gateStatus.count[7:6]};
        3'd1: ebusDataOut = gateStatus.count[5:0];
        3'd2: ebusDataOut = {mrReset,
                             syncStatus.eboxSync,
                             syncStatus.respLatched,
                             syncStatus.phase};
        3'd3: ebusDataOut = {rateSel, domainDis, 1'b0};
        // Selects 4 to 7 read as zero
        default: ebusDataOut = '0;
      endcase
    end
  end

endmodule

// ==== hdl/clkEboxSync.sv ====
`timescale 1ns/10ps

module clkEboxSync (
  input  logic                MBOX_CLK,
  input  logic                CLK,
  input  logic                srcTick,
  input  logic                mrReset,
  input  logic                mboxWait,
  input  logic                mboxRespIn,
  input  clkPkg::cramTimeT    cramTime,
  input  clkPkg::domainDisT   domainDis,
  output logic                eboxClk,
  output logic                crmClk,
  output logic                edpClk,
  output logic                ctlClk,
  output clkPkg::syncStatusT  syncStatus
);

  clkPkg::phaseT phase;
  clkPkg::phaseT nextPhase;
  clkPkg::phaseT syncPhase;
  logic eboxSync;
  logic respLatched;
  logic waitOk;
  logic eboxFire;
  logic syncHit;

  // MBox wait is satisfied by a response or held off by MR reset
  assign waitOk = ~mboxWait | respLatched | mrReset;

  // Sync point reached on a tick fires the EBox clock
  assign eboxFire = srcTick & eboxSync;

  // Phase counter saturates at 7
  assign nextPhase = (phase == 3'd7) ? phase : phase + 3'd1;

  // Sync once the phase passes the CRAM time field
  assign syncPhase = clkPkg::phaseT'(cramTime) + 3'd1;
  assign syncHit = (nextPhase >= syncPhase) & waitOk;

  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      phase <= '0;
      eboxSync <= 1'b0;
    end else if (eboxFire) begin
      // New EBox cycle starts counting from zero
      phase <= '0;
      eboxSync <= 1'b0;
    end else if (srcTick) begin
      phase <= nextPhase;
      eboxSync <= syncHit;
    end
  end

  // Response latch, dropped when the EBox clock is issued
  // A response on that same edge is kept
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      respLatched <= 1'b0;
    end else if (mboxRespIn) begin
      respLatched <= 1'b1;
    end else if (eboxFire) begin
      respLatched <= 1'b0;
    end
  end

  // One cycle EBox clock enable and its domain copies
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      eboxClk <= 1'b0;
      crmClk <= 1'b0;
      edpClk <= 1'b0;
      ctlClk <= 1'b0;
    end else begin
      eboxClk <= eboxFire;
      crmClk <= eboxFire & ~domainDis.crm;
      edpClk <= eboxFire & ~domainDis.edp;
      ctlClk <= eboxFire & ~domainDis.ctl;
    end
  end

  always_comb begin
    syncStatus.eboxSync = eboxSync;
    syncStatus.respLatched = respLatched;
    syncStatus.phase = phase;
  end

endmodule

// ==== hdl/clkGateCtl.sv ====
`timescale 1ns/10ps

module clkGateCtl (
  input  logic                MBOX_CLK,
  input  logic                CLK,
  input  clkPkg::ctlFuncT     ctlFunc,
  input  clkPkg::burstLoadT   burstLoad,
  input  clkPkg::rateSelT     rateSel,
  output logic                srcTick,
  output clkPkg::gateStatusT  gateStatus
);

  // Free running rate divider
  logic [2:0] rateDiv;
  logic [2:0] rateMask;
  logic rateTick;

  // Run flags
  logic go;
  logic burstMode;
  logic stepPending;

  // Burst counter
  clkPkg::burstCountT count;
  logic burstZero;
  logic burstDec;
  logic gateEn;

  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      rateDiv <= '0;
    end else begin
      rateDiv <= rateDiv + 3'd1;
    end
  end

  // Low rateSel bits of the divider must be zero
  // giving a tick every 1, 2, 4 or 8 cycles
  always_comb begin
    case (rateSel)
      2'd0: rateMask = 3'b000;
      2'd1: rateMask = 3'b001;
      2'd2: rateMask = 3'b011;
      default: rateMask = 3'b111;
    endcase
  end

  assign rateTick = (rateDiv & rateMask) == 3'b000;

  assign burstZero = (count == '0);

  // Clock runs on go, a pending step, or a burst with count left
  assign gateEn = go | stepPending | (burstMode & ~burstZero);
  assign srcTick = rateTick & gateEn;

  // Each tick in burst mode uses up one count
  assign burstDec = srcTick & burstMode & ~burstZero;

  // Go and burst mode reload on every control function
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      go <= 1'b0;
      burstMode <= 1'b0;
    end else if (ctlFunc.load) begin
      go <= ctlFunc.start;
      burstMode <= ctlFunc.burst;
    end
  end

  // Single step waits for the next paced tick
  // A fresh step request wins over the clearing tick
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      stepPending <= 1'b0;
    end else if (ctlFunc.step) begin
      stepPending <= 1'b1;
    end else if (srcTick) begin
      stepPending <= 1'b0;
    end
  end

  // Nibble loads take priority over the count down
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      count <= '0;
    end else if (burstLoad.loadLo || burstLoad.loadHi) begin
      if (burstLoad.loadLo) begin
        count[3:0] <= burstLoad.data;
      end
      if (burstLoad.loadHi) begin
        count[7:4] <= burstLoad.data;
      end
    end else if (burstDec) begin
      count <= count - 8'd1;
    end
  end

  always_comb begin
    gateStatus.go = go;
    gateStatus.burstMode = burstMode;
    gateStatus.stepPending = stepPending;
    gateStatus.burstZero = burstZero;
    gateStatus.count = count;
  end

endmodule

// ==== hdl/clkPkg.sv ====
package clkPkg;

  // Diagnostic function or read select, EBus ds bits 4 to 6
  typedef logic [2:0] diagSelT;

  // EBus write data, bits 32 to 35
  typedef logic [3:0] ebusNibbleT;

  // Diagnostic read-back word, bits 30 to 35
  typedef logic [5:0] ebusWordT;

  typedef logic [7:0] burstCountT;
  typedef logic [1:0] rateSelT;
  typedef logic [1:0] cramTimeT;
  typedef logic [2:0] phaseT;

  // Decoded control strobes, each valid for one cycle
  typedef struct packed {
    logic load;
    logic start;
    logic burst;
    logic step;
  } ctlFuncT;

  // Burst counter nibble loads
  typedef struct packed {
    logic loadLo;
    logic loadHi;
    ebusNibbleT data;
  } burstLoadT;

  // EBox domain clock disables, same order as the load data bits
  typedef struct packed {
    logic crm;
    logic edp;
    logic ctl;
  } domainDisT;

  typedef struct packed {
    logic go;
    logic burstMode;
    logic stepPending;
    logic burstZero;
    burstCountT count;
  } gateStatusT;

  typedef struct packed {
    logic eboxSync;
    logic respLatched;
    phaseT phase;
  } syncStatusT;

  // Control functions, qualified by diagCtl
  localparam diagSelT FUNC_START = 3'd1;
  localparam diagSelT FUNC_STEP = 3'd2;
  localparam diagSelT FUNC_BURST = 3'd5;
  localparam diagSelT FUNC_CLR_RESET = 3'd6;
  localparam diagSelT FUNC_SET_RESET = 3'd7;

  // Load functions, qualified by diagLd
  localparam diagSelT LD_BURST_LO = 3'd2;
  localparam diagSelT LD_BURST_HI = 3'd3;
  localparam diagSelT LD_RATE = 3'd4;
  localparam diagSelT LD_DIS = 3'd5;

endpackage

// ==== src.f ====
hdl/clkPkg.sv
hdl/clkDiagRegs.sv
hdl/clkGateCtl.sv
hdl/clkEboxSync.sv
hdl/clkBoard.sv
dv/clkBoard_checker.sv
dv/clkBoardTb.sv
